//--- vlog.f
+incdir+rtl
+incdir+verif
rtl/ps2_tr_pkg.sv
rtl/hid_key_queue.sv
rtl/hid_ps2_lookup.sv
rtl/ps2_credit_counter.sv
rtl/ps2_seq_fsm.sv
rtl/hid_ps2_translator.sv
verif/tb_hid_ps2_translator.sv

//--- Bender.yml
package:
  name: hid_ps2_translator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ps2_tr_pkg.sv
      - rtl/hid_key_queue.sv
      - rtl/hid_ps2_lookup.sv
      - rtl/ps2_credit_counter.sv
      - rtl/ps2_seq_fsm.sv
      - rtl/hid_ps2_translator.sv
  - target: simulation
    include_dirs:
      - rtl
      - verif
    files:
      - verif/tb_hid_ps2_translator.sv

//--- verif/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic abort_run(input string why);
	$display("%s", why);
	$display("=== FAIL ===");
	$fatal(1, "Testbench stopped on the first error");
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

// Holds key_valid until the queue takes the event
task automatic send_key(input ps2_tr_pkg::hid_code_t code, input logic rel);
	@(posedge clk);
	key_valid   <= 1'b1;
	key_code    <= code;
	key_release <= rel;
	@(negedge clk);
	while (!key_ready)
		@(negedge clk);
	@(posedge clk); // Accepted on this edge
	key_valid <= 1'b0;
endtask

// Set-2 order is E0 for an extended key, F0 for a release, then the code
task automatic key_event(input ps2_tr_pkg::hid_code_t hid, input ps2_tr_pkg::ps2_code_t code,
		input logic ext, input logic rel);
	send_key(hid, rel);
	if (ext)
		exp_q.push_back(ps2_tr_pkg::PS2_PREFIX_EXT);
	if (rel)
		exp_q.push_back(ps2_tr_pkg::PS2_PREFIX_BREAK);
	exp_q.push_back(code);
endtask

// Byte monitor that also tracks the credits the DUT holds
task automatic collect();
	forever begin
		@(negedge clk);
		if (rst) begin
			credits_held = `PS2_TR_CREDITS;
			bytes_seen   = 0;
		end else begin
			if (byte_valid) begin
				if (credits_held == 0)
					abort_run("byte_valid pulsed while the DUT held no credit");
				got_q.push_back(byte_data);
				bytes_seen++;
			end
			credits_held = credits_held - int'(byte_valid) + int'(byte_credit);
		end
	end
endtask

task automatic compare_bytes();
	while (got_q.size() < exp_q.size())
		@(negedge clk);
	repeat (8) @(negedge clk); // Window for any stray byte
	check("byte count", got_q.size(), exp_q.size());
	foreach (exp_q[i])
		check($sformatf("byte_data[%0d]", i), got_q[i], exp_q[i]);
	while (credits_held != `PS2_TR_CREDITS)
		@(negedge clk);
	got_q.delete();
	exp_q.delete();
endtask

task automatic test_presses();
	key_event(8'h04, 8'h1c, 1'b0, 1'b0); // A
	key_event(8'h1d, 8'h1a, 1'b0, 1'b0); // Z
	key_event(8'h28, 8'h5a, 1'b0, 1'b0); // Enter
	key_event(8'h45, 8'h07, 1'b0, 1'b0); // F12
	key_event(8'he1, 8'h12, 1'b0, 1'b0); // Left Shift
	compare_bytes();
endtask

task automatic test_releases();
	key_event(8'h04, 8'h1c, 1'b0, 1'b1);
	key_event(8'he1, 8'h12, 1'b0, 1'b1);
	compare_bytes();
endtask

task automatic test_extended();
	key_event(8'h52, 8'h75, 1'b1, 1'b0); // Up press
	key_event(8'h4f, 8'h74, 1'b1, 1'b1); // Right release
	key_event(8'he6, 8'h11, 1'b1, 1'b1); // Right Alt release
	compare_bytes();
endtask

// None of these may show up ahead of the A
task automatic test_unmapped();
	send_key(8'h00, 1'b0);
	send_key(8'h01, 1'b0);
	send_key(8'h68, 1'b0);
	send_key(8'h85, 1'b0);
	key_event(8'h04, 8'h1c, 1'b0, 1'b0);
	compare_bytes();
endtask

task automatic test_backpressure();
	hold_credits = 1'b1;
	key_event(8'he6, 8'h11, 1'b1, 1'b1); // Spends three of the four credits
	key_event(8'h04, 8'h1c, 1'b0, 1'b0);
	key_event(8'h1d, 8'h1a, 1'b0, 1'b0);
	key_event(8'h28, 8'h5a, 1'b0, 1'b0);
	key_event(8'h45, 8'h07, 1'b0, 1'b0);
	key_event(8'he1, 8'h12, 1'b0, 1'b0);
	key_event(8'h52, 8'h75, 1'b1, 1'b0);
	repeat (4) @(negedge clk);
	check("key_ready", key_ready, 1'b0); // Z in flight with four events queued
	check("bytes while held", got_q.size(), `PS2_TR_CREDITS);
	hold_credits = 1'b0;
	compare_bytes();
endtask

`endif

//--- verif/tb_hid_ps2_translator.sv
`default_nettype none

`include "ps2_tr_config.svh"

module tb_hid_ps2_translator;

// The whole run needs a few hundred cycles
localparam int TIMEOUT_CYCLES = 2000;

logic                  clk = 1'b0;
logic                  rst;
logic                  key_valid;
ps2_tr_pkg::hid_code_t key_code;
logic                  key_release;
logic                  byte_credit;
wire                   key_ready;
wire                   byte_valid;
wire ps2_tr_pkg::ps2_code_t byte_data;

ps2_tr_pkg::ps2_code_t got_q[$];
ps2_tr_pkg::ps2_code_t exp_q[$];

int     credits_held;     // DUT credit count as seen from the port
int     bytes_seen;
int     credits_sent;
int     credit_delay;
int     cycle_count = 0;
logic   hold_credits;
integer seed = 32'h9ae6;

`include "tb_tasks.svh"

hid_ps2_translator i_hid_ps2_translator (
	.clk         (clk),
	.rst         (rst),
	.key_valid   (key_valid),
	.key_code    (key_code),
	.key_release (key_release),
	.byte_credit (byte_credit),
	.key_ready   (key_ready),
	.byte_valid  (byte_valid),
	.byte_data   (byte_data)
);

always #2 clk = ~clk;

// Downstream transmitter hands back one credit per byte with 0 to 3 idle cycles between
always @(posedge clk) begin
	if (rst) begin
		byte_credit  <= 1'b0;
		credits_sent <= 0;
		credit_delay <= 0;
	end else if (!hold_credits && bytes_seen > credits_sent && credit_delay == 0) begin
		byte_credit  <= 1'b1;
		credits_sent <= credits_sent + 1;
		credit_delay <= $random(seed) & 3;
	end else begin
		byte_credit <= 1'b0;
		if (credit_delay != 0)
			credit_delay <= credit_delay - 1;
	end
end

always @(posedge clk) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count >= TIMEOUT_CYCLES)
		abort_run($sformatf("Timeout, run still going after %0d cycles", cycle_count));
end

initial collect();

initial begin
	rst          = 1'b1;
	key_valid    = 1'b0;
	key_code     = '0;
	key_release  = 1'b0;
	byte_credit  = 1'b0;
	hold_credits = 1'b0;
	repeat (5) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	check("key_ready", key_ready, 1'b1); // Empty queue after reset
	check("byte_valid", byte_valid, 1'b0);

	test_presses();
	test_releases();
	test_extended();
	test_unmapped();
	test_backpressure();

	$display("=== PASS ===");
	$finish;
end

endmodule

`default_nettype wire

//--- rtl/hid_ps2_translator.sv
`default_nettype none

`include "ps2_tr_config.svh"

module hid_ps2_translator (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   key_valid,
	input  wire ps2_tr_pkg::hid_code_t key_code,
	input  wire                   key_release,
	input  wire                   byte_credit,
	output wire                   key_ready,
	output wire                   byte_valid,
	output ps2_tr_pkg::ps2_code_t byte_data
);

wire                   q_empty;
wire                   q_pop;
ps2_tr_pkg::hid_code_t q_code;
wire                   q_release;
ps2_tr_pkg::ps2_code_t lk_code;
wire                   lk_ext;
wire                   lk_hit;
wire                   credit_avail;

// Pending key events
hid_key_queue i_hid_key_queue (
	.clk         (clk),
	.rst         (rst),
	.key_valid   (key_valid),
	.key_code    (key_code),
	.key_release (key_release),
	.q_pop       (q_pop),
	.key_ready   (key_ready),
	.q_empty     (q_empty),
	.q_code      (q_code),
	.q_release   (q_release)
);

hid_ps2_lookup i_hid_ps2_lookup (
	.clk     (clk),
	.rst     (rst),
	.q_pop   (q_pop),
	.q_code  (q_code),
	.lk_code (lk_code),
	.lk_ext  (lk_ext),
	.lk_hit  (lk_hit)
);

// Each byte sent is also a credit taken
ps2_credit_counter i_ps2_credit_counter (
	.clk          (clk),
	.rst          (rst),
	.byte_credit  (byte_credit),
	.take         (byte_valid),
	.credit_avail (credit_avail)
);

ps2_seq_fsm i_ps2_seq_fsm (
	.clk          (clk),
	.rst          (rst),
	.q_empty      (q_empty),
	.q_release    (q_release),
	.lk_code      (lk_code),
	.lk_ext       (lk_ext),
	.lk_hit       (lk_hit),
	.credit_avail (credit_avail),
	.q_pop        (q_pop),
	.byte_valid   (byte_valid),
	.byte_data    (byte_data)
);

endmodule

`default_nettype wire

//--- rtl/ps2_seq_fsm.sv
`default_nettype none

`include "ps2_tr_config.svh"

module ps2_seq_fsm (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   q_empty,
	input  wire                   q_release,
	input  wire ps2_tr_pkg::ps2_code_t lk_code,
	input  wire                   lk_ext,
	input  wire                   lk_hit,
	input  wire                   credit_avail,
	output logic                  q_pop,
	output logic                  byte_valid,
	output ps2_tr_pkg::ps2_code_t byte_data
);

ps2_tr_pkg::seq_state_e state;
ps2_tr_pkg::seq_state_e state_nx;
ps2_tr_pkg::seq_state_e head_state;
ps2_tr_pkg::seq_state_e tail_state;
ps2_tr_pkg::ps2_code_t  send_byte;
logic                   send;
logic                   rel;

assign q_pop = state == ps2_tr_pkg::SEQ_IDLE && !q_empty;

// Byte order is E0, F0, code with the prefixes optional
assign tail_state = rel ? ps2_tr_pkg::SEQ_BREAK : ps2_tr_pkg::SEQ_CODE;
assign head_state = lk_ext ? ps2_tr_pkg::SEQ_EXT : tail_state;

always_comb begin
	state_nx = state;
	send     = 1'b0;
	case (state)
		ps2_tr_pkg::SEQ_IDLE: begin
			if (!q_empty)
				state_nx = ps2_tr_pkg::SEQ_LOOKUP;
		end
		ps2_tr_pkg::SEQ_LOOKUP: begin
			if (!lk_hit) begin
				state_nx = ps2_tr_pkg::SEQ_IDLE; // Unmapped so nothing goes out
			end else if (credit_avail) begin
				send     = 1'b1;
				state_nx = head_state;
			end
		end
		ps2_tr_pkg::SEQ_EXT: begin
			if (credit_avail) begin
				send     = 1'b1;
				state_nx = tail_state;
			end
		end
		ps2_tr_pkg::SEQ_BREAK: begin
			if (credit_avail) begin
				send     = 1'b1;
				state_nx = ps2_tr_pkg::SEQ_CODE;
			end
		end
		ps2_tr_pkg::SEQ_CODE:  state_nx = ps2_tr_pkg::SEQ_IDLE;
		default:               state_nx = ps2_tr_pkg::SEQ_IDLE;
	endcase
end

// The state entered names the byte going out
always_comb begin
	case (state_nx)
		ps2_tr_pkg::SEQ_EXT:   send_byte = ps2_tr_pkg::PS2_PREFIX_EXT;
		ps2_tr_pkg::SEQ_BREAK: send_byte = ps2_tr_pkg::PS2_PREFIX_BREAK;
		default:               send_byte = lk_code;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		state      <= ps2_tr_pkg::SEQ_IDLE;
		byte_valid <= 1'b0;
		rel        <= 1'b0;
	end else begin
		state      <= state_nx;
		byte_valid <= send; // Single-cycle pulse per byte
		if (q_pop)
			rel <= q_release; // Lines up with the table register
	end
end

// Last byte stays on the bus while credits are out
always_ff @(posedge clk) begin
	if (send)
		byte_data <= send_byte;
end

endmodule

`default_nettype wire

//--- rtl/ps2_credit_counter.sv
`default_nettype none

`include "ps2_tr_config.svh"

module ps2_credit_counter (
	input  wire  clk,
	input  wire  rst,
	input  wire  byte_credit,
	input  wire  take,
	output logic credit_avail
);

localparam int CW = `PS2_TR_CREDIT_W;
localparam logic [CW-1:0] MAX_CREDITS = CW'(`PS2_TR_CREDITS);

logic [CW-1:0] count;
logic [CW-1:0] count_nx;

always_comb begin
	count_nx = count;
	if (byte_credit && !take && count != MAX_CREDITS)
		count_nx = count + 1'b1;
	else if (take && !byte_credit && count != '0)
		count_nx = count - 1'b1;
end

// The byte on the port this cycle is already charged, so the
// sequencer only sees what is left after it
assign credit_avail = count_nx != '0;

always_ff @(posedge clk) begin
	if (rst)
		count <= MAX_CREDITS;
	else
		count <= count_nx;
end

endmodule

`default_nettype wire

//--- rtl/hid_ps2_lookup.sv
`default_nettype none

`include "ps2_tr_config.svh"

module hid_ps2_lookup (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   q_pop,
	input  wire ps2_tr_pkg::hid_code_t q_code,
	output ps2_tr_pkg::ps2_code_t lk_code,
	output logic                  lk_ext,
	output logic                  lk_hit
);

// Bounds of the contiguous HID groups
localparam ps2_tr_pkg::hid_code_t KEY_HID_A          = 8'h04;
localparam ps2_tr_pkg::hid_code_t KEY_HID_Z          = 8'h1d;
localparam ps2_tr_pkg::hid_code_t KEY_HID_1          = 8'h1e;
localparam ps2_tr_pkg::hid_code_t KEY_HID_0          = 8'h27;
localparam ps2_tr_pkg::hid_code_t KEY_HID_ENTER      = 8'h28;
localparam ps2_tr_pkg::hid_code_t KEY_HID_SLASH      = 8'h38;
localparam ps2_tr_pkg::hid_code_t KEY_HID_CAPSLOCK   = 8'h39;
localparam ps2_tr_pkg::hid_code_t KEY_HID_F12        = 8'h45;
localparam ps2_tr_pkg::hid_code_t KEY_HID_SCROLLLOCK = 8'h47;
localparam ps2_tr_pkg::hid_code_t KEY_HID_INSERT     = 8'h49;
localparam ps2_tr_pkg::hid_code_t KEY_HID_UP         = 8'h52;

// Modifiers
localparam ps2_tr_pkg::hid_code_t KEY_HID_LEFTCTRL   = 8'he0;
localparam ps2_tr_pkg::hid_code_t KEY_HID_LEFTSHIFT  = 8'he1;
localparam ps2_tr_pkg::hid_code_t KEY_HID_LEFTALT    = 8'he2;
localparam ps2_tr_pkg::hid_code_t KEY_HID_LEFTMETA   = 8'he3;
localparam ps2_tr_pkg::hid_code_t KEY_HID_RIGHTCTRL  = 8'he4;
localparam ps2_tr_pkg::hid_code_t KEY_HID_RIGHTSHIFT = 8'he5;
localparam ps2_tr_pkg::hid_code_t KEY_HID_RIGHTALT   = 8'he6;
localparam ps2_tr_pkg::hid_code_t KEY_HID_RIGHTMETA  = 8'he7;

localparam ps2_tr_pkg::ps2_code_t KEY_PS2_SCROLLLOCK = 8'h7e;
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_LEFTCTRL   = 8'h14;
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_LEFTSHIFT  = 8'h12;
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_LEFTALT    = 8'h11;
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_LEFTMETA   = 8'h1f; // E0
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_RIGHTCTRL  = 8'h14; // E0
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_RIGHTSHIFT = 8'h59;
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_RIGHTALT   = 8'h11; // E0
localparam ps2_tr_pkg::ps2_code_t KEY_PS2_RIGHTMETA  = 8'h27; // E0

// A to Z
localparam ps2_tr_pkg::ps2_code_t [0:25] PS2_LETTERS = {
	8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43,
	8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d,
	8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a
};

// 1 to 9, then 0
localparam ps2_tr_pkg::ps2_code_t [0:9] PS2_DIGITS = {
	8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45
};

// Enter, Esc, Backspace, Tab, Space, then punctuation up to Slash
localparam ps2_tr_pkg::ps2_code_t [0:16] PS2_PUNCT = {
	8'h5a, 8'h76, 8'h66, 8'h0d, 8'h29, 8'h4e, 8'h55, 8'h54, 8'h5b,
	8'h5d, 8'h5d, 8'h4c, 8'h52, 8'h0e, 8'h41, 8'h49, 8'h4a
};

// Caps Lock, F1 to F12
localparam ps2_tr_pkg::ps2_code_t [0:12] PS2_FKEYS = {
	8'h58, 8'h05, 8'h06, 8'h04, 8'h0c, 8'h03, 8'h0b, 8'h83, 8'h0a,
	8'h01, 8'h09, 8'h78, 8'h07
};

// Insert, Home, PgUp, Delete, End, PgDn, Right, Left, Down, Up (all E0)
localparam ps2_tr_pkg::ps2_code_t [0:9] PS2_NAV = {
	8'h70, 8'h6c, 8'h7d, 8'h71, 8'h69, 8'h7a, 8'h74, 8'h6b, 8'h72, 8'h75
};

ps2_tr_pkg::ps2_code_t tbl_code;
logic                  tbl_ext;
logic                  tbl_hit;

always_comb begin
	tbl_code = '0;
	tbl_ext  = 1'b0;
	tbl_hit  = 1'b1;
	case (q_code) inside
		[KEY_HID_A:KEY_HID_Z]:           tbl_code = PS2_LETTERS[q_code - KEY_HID_A];
		[KEY_HID_1:KEY_HID_0]:           tbl_code = PS2_DIGITS[q_code - KEY_HID_1];
		[KEY_HID_ENTER:KEY_HID_SLASH]:   tbl_code = PS2_PUNCT[q_code - KEY_HID_ENTER];
		[KEY_HID_CAPSLOCK:KEY_HID_F12]:  tbl_code = PS2_FKEYS[q_code - KEY_HID_CAPSLOCK];
		KEY_HID_SCROLLLOCK:              tbl_code = KEY_PS2_SCROLLLOCK;
		[KEY_HID_INSERT:KEY_HID_UP]: begin
			tbl_ext  = 1'b1;
			tbl_code = PS2_NAV[q_code - KEY_HID_INSERT];
		end
		KEY_HID_LEFTCTRL:                tbl_code = KEY_PS2_LEFTCTRL;
		KEY_HID_LEFTSHIFT:               tbl_code = KEY_PS2_LEFTSHIFT;
		KEY_HID_LEFTALT:                 tbl_code = KEY_PS2_LEFTALT;
		KEY_HID_RIGHTSHIFT:              tbl_code = KEY_PS2_RIGHTSHIFT;
		KEY_HID_LEFTMETA: begin
			tbl_ext  = 1'b1;
			tbl_code = KEY_PS2_LEFTMETA;
		end
		KEY_HID_RIGHTCTRL: begin
			tbl_ext  = 1'b1;
			tbl_code = KEY_PS2_RIGHTCTRL;
		end
		KEY_HID_RIGHTALT: begin
			tbl_ext  = 1'b1;
			tbl_code = KEY_PS2_RIGHTALT;
		end
		KEY_HID_RIGHTMETA: begin
			tbl_ext  = 1'b1;
			tbl_code = KEY_PS2_RIGHTMETA;
		end
		default:                         tbl_hit = 1'b0; // Dropped or undefined usage
	endcase
end

always_ff @(posedge clk) begin
	if (rst)
		lk_hit <= 1'b0;
	else if (q_pop)
		lk_hit <= tbl_hit;
end

// Result held until the next pop
always_ff @(posedge clk) begin
	if (q_pop) begin
		lk_code <= tbl_code;
		lk_ext  <= tbl_ext;
	end
end

endmodule

`default_nettype wire

//--- rtl/hid_key_queue.sv
`default_nettype none

`include "ps2_tr_config.svh"

module hid_key_queue (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   key_valid,
	input  wire ps2_tr_pkg::hid_code_t key_code,
	input  wire                   key_release,
	input  wire                   q_pop,
	output logic                  key_ready,
	output logic                  q_empty,
	output ps2_tr_pkg::hid_code_t q_code,
	output logic                  q_release
);

localparam int DEPTH = `PS2_TR_QUEUE_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

ps2_tr_pkg::hid_code_t code_mem [DEPTH];
logic                  rel_mem  [DEPTH];

logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             push;
logic             pop;

// Circular increment for a depth that need not be a power of two
function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
	if (ptr == PTR_W'(DEPTH - 1))
		return '0;
	return ptr + 1'b1;
endfunction

assign key_ready = count < DEPTH;
assign q_empty   = count == '0;
assign push      = key_valid && key_ready;
assign pop       = q_pop && !q_empty;

assign q_code    = code_mem[rd_ptr]; // Head seen without delay
assign q_release = rel_mem[rd_ptr];

always_ff @(posedge clk) begin
	if (push) begin
		code_mem[wr_ptr] <= key_code;
		rel_mem[wr_ptr]  <= key_release;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (pop)
			rd_ptr <= ptr_inc(rd_ptr);
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count; // Both or neither
		endcase
	end
end

endmodule

`default_nettype wire

//--- rtl/ps2_tr_pkg.sv
`default_nettype none

`include "ps2_tr_config.svh"

package ps2_tr_pkg;

	// USB HID keyboard usage code
	typedef logic [`PS2_TR_HID_W-1:0] hid_code_t;

	// Byte on the PS/2 side
	typedef logic [`PS2_TR_CODE_W-1:0] ps2_code_t;

	// Prefix bytes of set 2
	typedef enum ps2_code_t {
		PS2_PREFIX_EXT   = 8'he0, // Extended key
		PS2_PREFIX_BREAK = 8'hf0  // Key release
	} ps2_prefix_e;

	// Sequencer states
	// EXT, BREAK and CODE name the byte most recently put on the port
	typedef enum logic [2:0] {
		SEQ_IDLE   = 3'd0, // Waiting for a queued event
		SEQ_LOOKUP = 3'd1, // Table result valid
		SEQ_EXT    = 3'd2, // E0 sent
		SEQ_BREAK  = 3'd3, // F0 sent
		SEQ_CODE   = 3'd4  // Scan code sent, event done
	} seq_state_e;

endpackage

`default_nettype wire

//--- rtl/ps2_tr_config.svh
`ifndef PS2_TR_CONFIG_SVH
`define PS2_TR_CONFIG_SVH

// HID usage code width
`define PS2_TR_HID_W 8

// One PS/2 set-2 byte
`define PS2_TR_CODE_W 8

// Key events waiting ahead of the sequencer
`define PS2_TR_QUEUE_DEPTH 4

// Credits after reset and the ceiling of the counter
`define PS2_TR_CREDITS 4

// Must hold PS2_TR_CREDITS
`define PS2_TR_CREDIT_W 3

`endif
